/* Makefile */
# Verilator build and run for the data cache hit stage testbench

VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= dcache_hit_tb
FLIST      ?= flist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := all tests passed

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line in the output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* dv/dcache_hit_tb.sv */
// Data cache hit stage testbench
// Directed tests for read hits, write buffer and bypass, clean and
// dirty misses, and BIU error pass-through

`default_nettype none

`include "dcache_hit_defines.svh"

module dcache_hit_tb
  import dcache_hit_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 8;
  // Directed tests need well under a hundred cycles
  localparam int WATCHDOG_CYCLES = 1250;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      req_i, wreq_i, flush_i, stall_o, ack_o, err_o;
  plen_t     adr_i, biu_adro_i, evictbuffer_adr_o;
  xbe_t      be_i;
  xlen_t     d_i, q_o, biu_q_i, writebuffer_data_o;
  logic      cache_hit_i, way_dirty_i, armed_o, filling_o;
  way_t      ways_hit_i, fill_way_i, fill_way_o, writebuffer_ways_hit_o;
  blk_t      cache_line_i, evict_line_i, evictbuffer_line_o;
  tag_t      evict_tag_i, core_tag_o;
  idx_t      idx_o, writebuffer_idx_o;
  logic      writebuffer_we_o, writebuffer_ack_i;
  dat_offs_t writebuffer_offs_o;
  blk_be_t   writebuffer_be_o;
  biucmd_e   biucmd_o;
  logic      biucmd_ack_i, biucmd_busy_i, biu_ack_i, biu_err_i;

  // xorshift state
  xlen_t rng_state = 32'd54;

  dcache_hit dcache_hit_i (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Stimulus and expected-value helpers
  //////////////////////////////////////////////////////////////////////

  function automatic xlen_t next_random();
    xlen_t x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  function automatic blk_t random_line();
    blk_t line;
    for (int i = 0; i < `DC_BLK_BITS/`DC_XLEN; i++)
    begin
      line[i*`DC_XLEN +: `DC_XLEN] = next_random();
    end
    return line;
  endfunction

  // Byte address of a word from tag, set and word offset
  function automatic plen_t make_adr(input tag_t tag, input idx_t idx, input dat_offs_t off);
    return {tag, idx, off, {`DC_WORD_LSB{1'b0}}};
  endfunction

  function automatic xlen_t line_word(input blk_t line, input dat_offs_t off);
    blk_t shifted;
    shifted = line >> (int'(off) * `DC_XLEN);
    return shifted[`DC_XLEN-1:0];
  endfunction

  // Written bytes replace the old ones
  function automatic xlen_t merge_bytes(input xlen_t word, input xlen_t d, input xbe_t be);
    xlen_t w;
    w = word;
    for (int b = 0; b < `DC_XLEN/8; b++)
    begin
      if (be[b])
        w[b*8 +: 8] = d[b*8 +: 8];
    end
    return w;
  endfunction

  // Word enables placed at the word's bytes within the line
  function automatic blk_be_t line_be(input xbe_t be, input dat_offs_t off);
    blk_be_t r;
    r = '0;
    for (int b = 0; b < `DC_XLEN/8; b++)
    begin
      r[int'(off) * (`DC_XLEN/8) + b] = be[b];
    end
    return r;
  endfunction

  task automatic drive_idle();
    req_i             <= 1'b0;
    wreq_i            <= 1'b0;
    flush_i           <= 1'b0;
    biu_ack_i         <= 1'b0;
    biucmd_ack_i      <= 1'b0;
    biu_err_i         <= 1'b0;
    writebuffer_ack_i <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic report_fail();
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s expected %b got %b", $time, name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_xlen(input string name, input xlen_t expected, input xlen_t actual);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_plen(input string name, input plen_t expected, input plen_t actual);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_blk(input string name, input blk_t expected, input blk_t actual);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_blk_be(input string name, input blk_be_t expected,
                              input blk_be_t actual);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, expected, actual);
      report_fail();
    end
  endtask

  task automatic check_cmd(input string name, input biucmd_e expected, input biucmd_e actual);
    if (actual !== expected)
    begin
      $display("[FAIL] t=%0t %s expected %s got %s", $time, name, expected.name(),
               actual.name());
      report_fail();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state_test();
    @(negedge clk_i);
    check_bit("armed_o", 1'b1, armed_o);
    check_bit("filling_o", 1'b0, filling_o);
    check_cmd("biucmd_o", NOP, biucmd_o);
    check_bit("ack_o", 1'b0, ack_o);
    check_bit("writebuffer_we_o", 1'b0, writebuffer_we_o);
  endtask

  task automatic read_hit_test();
    blk_t line;
    tag_t tag;
    idx_t idx;
    plen_t adr;
    for (int i = 0; i < 4; i++)
    begin
      line = random_line();
      tag  = tag_t'(next_random());
      idx  = idx_t'(next_random());
      adr  = make_adr(tag, idx, dat_offs_t'(i));
      @(posedge clk_i);
      req_i        <= 1'b1;
      cache_hit_i  <= 1'b1;
      ways_hit_i   <= way_t'(2'b01);
      adr_i        <= adr;
      cache_line_i <= line;
      @(negedge clk_i);
      check_bit("stall_o", 1'b0, stall_o);
      // Memory lookup fields come straight from the address
      check_xlen("idx_o", xlen_t'(idx), xlen_t'(idx_o));
      check_xlen("core_tag_o", xlen_t'(tag), xlen_t'(core_tag_o));
      @(posedge clk_i);
      drive_idle();
      @(negedge clk_i);
      check_bit("ack_o", 1'b1, ack_o);
      check_xlen("q_o", line_word(line, dat_offs_t'(i)), q_o);
      // Same hit under pipe flush
      @(posedge clk_i);
      req_i   <= 1'b1;
      flush_i <= 1'b1;
      @(posedge clk_i);
      drive_idle();
      @(negedge clk_i);
      check_bit("ack_o", 1'b0, ack_o);
    end
  endtask

  task automatic write_hit_test();
    blk_t line;
    xlen_t d;
    tag_t tag;
    idx_t idx;
    dat_offs_t off;
    xbe_t be;
    line = random_line();
    d    = next_random();
    tag  = tag_t'(next_random());
    idx  = 4'h5;
    off  = 2'd2;
    be   = 4'b0110;
    @(posedge clk_i);
    wreq_i      <= 1'b1;
    cache_hit_i <= 1'b1;
    ways_hit_i  <= way_t'(2'b10);
    adr_i       <= make_adr(tag, idx, off);
    be_i        <= be;
    d_i         <= d;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_bit("writebuffer_we_o", 1'b1, writebuffer_we_o);
    check_xlen("writebuffer_idx_o", xlen_t'(idx), xlen_t'(writebuffer_idx_o));
    check_xlen("writebuffer_offs_o", xlen_t'(off), xlen_t'(writebuffer_offs_o));
    check_xlen("writebuffer_data_o", d, writebuffer_data_o);
    check_blk_be("writebuffer_be_o", line_be(be, off), writebuffer_be_o);
    check_xlen("writebuffer_ways_hit_o", xlen_t'(2'b10), xlen_t'(writebuffer_ways_hit_o));
    // Read of the same word sees the pending bytes
    @(posedge clk_i);
    req_i        <= 1'b1;
    cache_line_i <= line;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_bit("ack_o", 1'b1, ack_o);
    check_xlen("q_o", merge_bytes(line_word(line, off), d, be), q_o);
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b1;
    @(posedge clk_i);
    writebuffer_ack_i <= 1'b0;
    @(negedge clk_i);
    check_bit("writebuffer_we_o", 1'b0, writebuffer_we_o);
    // Write hit under flush is dropped
    @(posedge clk_i);
    wreq_i  <= 1'b1;
    flush_i <= 1'b1;
    @(posedge clk_i);
    drive_idle();
    @(negedge clk_i);
    check_bit("writebuffer_we_o", 1'b0, writebuffer_we_o);
  endtask

  // Presents a missing request, returns with req_i still high
  task automatic start_miss(input plen_t adr, input logic dirty, input way_t way);
    @(posedge clk_i);
    req_i       <= 1'b1;
    cache_hit_i <= 1'b0;
    way_dirty_i <= dirty;
    fill_way_i  <= way;
    adr_i       <= adr;
    @(negedge clk_i);
    check_bit("stall_o", 1'b1, stall_o);
  endtask

  task automatic clean_miss_test();
    tag_t tag;
    xlen_t word;
    tag  = tag_t'(next_random());
    word = next_random();
    start_miss(make_adr(tag, 4'h9, 2'd1), 1'b0, way_t'(2'b10));
    @(negedge clk_i);
    check_cmd("biucmd_o", READWAY, biucmd_o);
    check_bit("filling_o", 1'b1, filling_o);
    check_bit("armed_o", 1'b0, armed_o);
    check_xlen("fill_way_o", xlen_t'(2'b10), xlen_t'(fill_way_o));
    check_bit("stall_o", 1'b1, stall_o);
    // Another word of the line first, then the requested one
    @(posedge clk_i);
    biu_ack_i  <= 1'b1;
    biu_adro_i <= make_adr(tag, 4'h9, 2'd0);
    biu_q_i    <= next_random();
    @(negedge clk_i);
    check_bit("stall_o", 1'b1, stall_o);
    @(posedge clk_i);
    biu_adro_i <= make_adr(tag, 4'h9, 2'd1);
    biu_q_i    <= word;
    @(negedge clk_i);
    check_bit("stall_o", 1'b0, stall_o);
    @(posedge clk_i);
    drive_idle();
    biucmd_ack_i <= 1'b1;
    @(negedge clk_i);
    check_bit("ack_o", 1'b1, ack_o);
    check_xlen("q_o", word, q_o);
    @(posedge clk_i);
    biucmd_ack_i <= 1'b0;
    @(negedge clk_i);
    check_cmd("biucmd_o", NOP, biucmd_o);
    check_bit("filling_o", 1'b0, filling_o);
    check_bit("armed_o", 1'b0, armed_o);
    @(negedge clk_i);
    check_bit("armed_o", 1'b1, armed_o);
  endtask

  task automatic dirty_miss_test();
    tag_t et;
    blk_t el;
    et = tag_t'(next_random());
    el = random_line();
    @(posedge clk_i);
    evict_tag_i  <= et;
    evict_line_i <= el;
    start_miss(make_adr(tag_t'(next_random()), 4'h3, 2'd0), 1'b1, way_t'(2'b01));
    // Victim changes after capture and must not show up
    @(posedge clk_i);
    req_i        <= 1'b0;
    evict_tag_i  <= ~et;
    evict_line_i <= ~el;
    @(negedge clk_i);
    check_cmd("biucmd_o", READWAY, biucmd_o);
    check_plen("evictbuffer_adr_o", make_adr(et, 4'h3, 2'd0), evictbuffer_adr_o);
    check_blk("evictbuffer_line_o", el, evictbuffer_line_o);
    @(posedge clk_i);
    biucmd_ack_i <= 1'b1;
    @(posedge clk_i);
    biucmd_ack_i <= 1'b0;
    @(negedge clk_i);
    check_cmd("biucmd_o", WRITEWAY, biucmd_o);
    check_bit("filling_o", 1'b0, filling_o);
    check_plen("evictbuffer_adr_o", make_adr(et, 4'h3, 2'd0), evictbuffer_adr_o);
    check_blk("evictbuffer_line_o", el, evictbuffer_line_o);
    @(negedge clk_i);
    check_cmd("biucmd_o", NOP, biucmd_o);
    check_bit("armed_o", 1'b1, armed_o);
  endtask

  task automatic error_test();
    @(posedge clk_i);
    biu_err_i <= 1'b1;
    @(posedge clk_i);
    biu_err_i <= 1'b0;
    @(negedge clk_i);
    check_bit("err_o", 1'b1, err_o);
    @(negedge clk_i);
    check_bit("err_o", 1'b0, err_o);
    // Error in the middle of a fill ends it
    start_miss(make_adr(tag_t'(next_random()), 4'hc, 2'd3), 1'b0, way_t'(2'b01));
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    check_bit("filling_o", 1'b1, filling_o);
    @(posedge clk_i);
    biu_err_i <= 1'b1;
    @(posedge clk_i);
    biu_err_i <= 1'b0;
    @(negedge clk_i);
    check_bit("err_o", 1'b1, err_o);
    check_cmd("biucmd_o", NOP, biucmd_o);
    check_bit("filling_o", 1'b0, filling_o);
    @(negedge clk_i);
    check_bit("armed_o", 1'b1, armed_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_ni        <= 1'b0;
    drive_idle();
    adr_i         <= '0;
    be_i          <= '0;
    d_i           <= '0;
    cache_hit_i   <= 1'b0;
    way_dirty_i   <= 1'b0;
    ways_hit_i    <= '0;
    fill_way_i    <= '0;
    cache_line_i  <= '0;
    evict_line_i  <= '0;
    evict_tag_i   <= '0;
    biucmd_busy_i <= 1'b0;
    biu_q_i       <= '0;
    biu_adro_i    <= '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    reset_state_test();
    read_hit_test();
    write_hit_test();
    clean_miss_test();
    dirty_miss_test();
    error_test();
    @(posedge clk_i);
    $display("all tests passed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_CYCLES * CLK_PERIOD);
    report_fail();
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+rtl
rtl/dcache_hit_pkg.sv
rtl/dcache_miss_fsm.sv
rtl/dcache_write_buffer.sv
rtl/dcache_read_path.sv
rtl/dcache_hit.sv
dv/dcache_hit_tb.sv

/* rtl/dcache_hit.sv */
// Data cache hit stage
// Hit detection, write buffering, read bypass and miss handling
// between the core pipe, the cache memories and the BIU

`default_nettype none

`include "dcache_hit_defines.svh"

module dcache_hit
  import dcache_hit_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  // Core side
  input  logic      req_i,
  input  logic      wreq_i,
  input  logic      flush_i,
  input  plen_t     adr_i,
  input  xbe_t      be_i,
  input  xlen_t     d_i,
  output logic      stall_o,
  output logic      ack_o,
  output logic      err_o,
  output xlen_t     q_o,

  // Tag/data memories
  input  logic      cache_hit_i,
  input  logic      way_dirty_i,
  input  way_t      ways_hit_i,
  input  way_t      fill_way_i,
  input  blk_t      cache_line_i,
  input  blk_t      evict_line_i,
  input  tag_t      evict_tag_i,
  output idx_t      idx_o,
  output tag_t      core_tag_o,
  output logic      armed_o,
  output logic      filling_o,
  output way_t      fill_way_o,

  // Write buffer
  output logic      writebuffer_we_o,
  input  logic      writebuffer_ack_i,
  output idx_t      writebuffer_idx_o,
  output dat_offs_t writebuffer_offs_o,
  output xlen_t     writebuffer_data_o,
  output blk_be_t   writebuffer_be_o,
  output way_t      writebuffer_ways_hit_o,

  // Evict buffer
  output plen_t     evictbuffer_adr_o,
  output blk_t      evictbuffer_line_o,

  // BIU
  output biucmd_e   biucmd_o,
  input  logic      biucmd_ack_i,
  input  logic      biucmd_busy_i,
  input  logic      biu_ack_i,
  input  logic      biu_err_i,
  input  xlen_t     biu_q_i,
  input  plen_t     biu_adro_i
);

  dat_offs_t dat_offs;

  //////////////////////////////////////////////////////////////////////
  // Address fields
  //////////////////////////////////////////////////////////////////////

  assign idx_o      = adr_i[`DC_BLK_OFFS_BITS +: `DC_IDX_BITS];
  assign core_tag_o = adr_i[`DC_PLEN-1 -: `DC_TAG_BITS];
  // Word within the line
  assign dat_offs   = adr_i[`DC_BLK_OFFS_BITS-1 -: `DC_DAT_OFFS_BITS];

  // BIU error, one cycle late like ack
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni) err_o <= 1'b0;
    else         err_o <= biu_err_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  dcache_miss_fsm u_miss_fsm (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .req_i              (req_i),
    .flush_i            (flush_i),
    .adr_i              (adr_i),
    .cache_hit_i        (cache_hit_i),
    .way_dirty_i        (way_dirty_i),
    .idx_i              (idx_o),
    .fill_way_i         (fill_way_i),
    .evict_tag_i        (evict_tag_i),
    .evict_line_i       (evict_line_i),
    .biucmd_ack_i       (biucmd_ack_i),
    .biucmd_busy_i      (biucmd_busy_i),
    .biu_ack_i          (biu_ack_i),
    .biu_err_i          (biu_err_i),
    .biu_adro_i         (biu_adro_i),
    .stall_o            (stall_o),
    .ack_o              (ack_o),
    .armed_o            (armed_o),
    .filling_o          (filling_o),
    .fill_way_o         (fill_way_o),
    .biucmd_o           (biucmd_o),
    .evictbuffer_adr_o  (evictbuffer_adr_o),
    .evictbuffer_line_o (evictbuffer_line_o)
  );

  dcache_write_buffer u_write_buffer (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .wreq_i                 (wreq_i),
    .flush_i                (flush_i),
    .cache_hit_i            (cache_hit_i),
    .idx_i                  (idx_o),
    .offs_i                 (dat_offs),
    .d_i                    (d_i),
    .be_i                   (be_i),
    .ways_hit_i             (ways_hit_i),
    .writebuffer_ack_i      (writebuffer_ack_i),
    .writebuffer_we_o       (writebuffer_we_o),
    .writebuffer_idx_o      (writebuffer_idx_o),
    .writebuffer_offs_o     (writebuffer_offs_o),
    .writebuffer_data_o     (writebuffer_data_o),
    .writebuffer_be_o       (writebuffer_be_o),
    .writebuffer_ways_hit_o (writebuffer_ways_hit_o)
  );

  // Read path sees the pending buffer entry for bypass
  dcache_read_path u_read_path (
    .clk_i        (clk_i),
    .idx_i        (idx_o),
    .offs_i       (dat_offs),
    .cache_hit_i  (cache_hit_i),
    .cache_line_i (cache_line_i),
    .wb_we_i      (writebuffer_we_o),
    .wb_idx_i     (writebuffer_idx_o),
    .wb_data_i    (writebuffer_data_o),
    .wb_be_i      (writebuffer_be_o),
    .biu_q_i      (biu_q_i),
    .q_o          (q_o)
  );

endmodule

`default_nettype wire

/* rtl/dcache_hit_defines.svh */
// Data cache hit stage geometry
// Fixed word, address and line sizes shared by package, RTL and testbench

`ifndef DCACHE_HIT_DEFINES_SVH
`define DCACHE_HIT_DEFINES_SVH

// Data word and physical address widths
`define DC_XLEN 32
`define DC_PLEN 32

// Two-way set associative
`define DC_WAYS 2

// 16-byte lines, four words each
`define DC_BLK_BITS 128
`define DC_BLK_OFFS_BITS 4

// 16 sets
`define DC_IDX_BITS 4

// Word within line
`define DC_DAT_OFFS_BITS 2

// What is left of the address above index and line offset
`define DC_TAG_BITS (`DC_PLEN - `DC_IDX_BITS - `DC_BLK_OFFS_BITS)

// Byte within word
`define DC_WORD_LSB 2

`endif

/* rtl/dcache_hit_pkg.sv */
// Data cache hit stage types
// Field types and state/command encodings for RTL and testbench

`default_nettype none

`include "dcache_hit_defines.svh"

package dcache_hit_pkg;

  // Data and address
  typedef logic [`DC_XLEN-1:0]       xlen_t;
  typedef logic [`DC_PLEN-1:0]       plen_t;
  typedef logic [`DC_XLEN/8-1:0]     xbe_t;

  // Whole line and its byte enables
  typedef logic [`DC_BLK_BITS-1:0]   blk_t;
  typedef logic [`DC_BLK_BITS/8-1:0] blk_be_t;

  // Address fields
  typedef logic [`DC_IDX_BITS-1:0]      idx_t;
  typedef logic [`DC_TAG_BITS-1:0]      tag_t;
  typedef logic [`DC_DAT_OFFS_BITS-1:0] dat_offs_t;

  // One bit per way, one-hot where a single way is meant
  typedef logic [`DC_WAYS-1:0] way_t;

  // Memory FSM states
  typedef enum logic [1:0] {ARMED, EVICT, WAIT_FILL, RECOVER} memfsm_state_e;

  // BIU commands
  typedef enum logic [1:0] {NOP, READWAY, WRITEWAY} biucmd_e;

endpackage

`default_nettype wire

/* rtl/dcache_miss_fsm.sv */
// Data cache miss FSM
// Sequences line fill and dirty-line eviction through the BIU,
// drives stall and the registered read acknowledge

`default_nettype none

`include "dcache_hit_defines.svh"

module dcache_miss_fsm
  import dcache_hit_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,

  // Upstream request
  input  logic    req_i,
  input  logic    flush_i,
  input  plen_t   adr_i,

  // Tag/data memory status
  input  logic    cache_hit_i,
  input  logic    way_dirty_i,
  input  idx_t    idx_i,
  input  way_t    fill_way_i,
  input  tag_t    evict_tag_i,
  input  blk_t    evict_line_i,

  // BIU
  input  logic    biucmd_ack_i,
  input  logic    biucmd_busy_i,
  input  logic    biu_ack_i,
  input  logic    biu_err_i,
  input  plen_t   biu_adro_i,

  output logic    stall_o,
  output logic    ack_o,
  output logic    armed_o,
  output logic    filling_o,
  output way_t    fill_way_o,
  output biucmd_e biucmd_o,
  output plen_t   evictbuffer_adr_o,
  output blk_t    evictbuffer_line_o
);

  memfsm_state_e memfsm_state;

  logic cache_ack;
  logic word_ack;
  logic biu_adr_match;
  logic miss_start;
  logic fill_done;
  logic hit_req;

  //////////////////////////////////////////////////////////////////////
  // Request qualifiers
  //////////////////////////////////////////////////////////////////////

  // Returned BIU word is the one the core is asking for
  assign biu_adr_match = (biu_adro_i[`DC_PLEN-1:`DC_WORD_LSB] == adr_i[`DC_PLEN-1:`DC_WORD_LSB]);

  assign hit_req   = req_i & cache_hit_i;
  assign cache_ack = hit_req & ~flush_i;
  assign word_ack  = req_i & biu_ack_i & biu_adr_match & ~flush_i;

  // Only one fill in flight, so wait while the BIU is busy
  assign miss_start = req_i & ~cache_hit_i & ~flush_i & ~biucmd_busy_i;

  // Error also ends the command
  assign fill_done = biucmd_ack_i | biu_err_i;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      memfsm_state <= ARMED;
      armed_o      <= 1'b1;
      filling_o    <= 1'b0;
      fill_way_o   <= '0;
      biucmd_o     <= NOP;
    end
    else
    begin
      case (memfsm_state)
        ARMED:
        begin
          if (miss_start)
          begin
            // Dirty victim: fetch new line first, write old one after
            memfsm_state <= way_dirty_i ? EVICT : WAIT_FILL;
            biucmd_o     <= READWAY;
            armed_o      <= 1'b0;
            filling_o    <= 1'b1;
            fill_way_o   <= fill_way_i;
          end
          else
          begin
            biucmd_o <= NOP;
          end
        end
        WAIT_FILL:
        begin
          if (fill_done)
          begin
            memfsm_state <= RECOVER;
            biucmd_o     <= NOP;
            filling_o    <= 1'b0;
          end
        end
        EVICT:
        begin
          if (fill_done)
          begin
            // Eviction command lives for the single RECOVER cycle
            memfsm_state <= RECOVER;
            biucmd_o     <= WRITEWAY;
            filling_o    <= 1'b0;
          end
        end
        default:
        begin
          // RECOVER: memories re-read after the fill
          memfsm_state <= ARMED;
          biucmd_o     <= NOP;
          armed_o      <= 1'b1;
        end
      endcase
    end
  end

  // Evict buffer follows the victim way while armed
  always_ff @(posedge clk_i)
  begin
    if (memfsm_state == ARMED)
    begin
      evictbuffer_adr_o  <= {evict_tag_i, idx_i, {`DC_BLK_OFFS_BITS{1'b0}}};
      evictbuffer_line_o <= evict_line_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stall and acknowledge
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (memfsm_state)
      ARMED:     stall_o = req_i & ~cache_hit_i;
      WAIT_FILL,
      EVICT:     stall_o = ~(word_ack | hit_req);
      default:   stall_o = ~hit_req;
    endcase
  end

  // Fill states also ack straight from the BIU return
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      ack_o <= 1'b0;
    end
    else if (memfsm_state == WAIT_FILL || memfsm_state == EVICT)
    begin
      ack_o <= cache_ack | word_ack;
    end
    else
    begin
      ack_o <= cache_ack;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////////////////////////

  a_fill_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    filling_o |-> $onehot(fill_way_o));

  a_readway_in_fill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (biucmd_o == READWAY) |-> (memfsm_state == WAIT_FILL || memfsm_state == EVICT));

endmodule

`default_nettype wire

/* rtl/dcache_read_path.sv */
// Data cache read path
// Merges a pending buffered write into the line, selects the
// addressed word and registers it or the BIU word

`default_nettype none

`include "dcache_hit_defines.svh"

module dcache_read_path
  import dcache_hit_pkg::*;
(
  input  logic      clk_i,

  // Current access
  input  idx_t      idx_i,
  input  dat_offs_t offs_i,
  input  logic      cache_hit_i,
  input  blk_t      cache_line_i,

  // Pending write buffer entry
  input  logic      wb_we_i,
  input  idx_t      wb_idx_i,
  input  xlen_t     wb_data_i,
  input  blk_be_t   wb_be_i,

  // BIU fill word
  input  xlen_t     biu_q_i,

  output xlen_t     q_o
);

  logic  bypass;
  blk_t  wb_line;
  blk_t  merged_line;
  xlen_t cache_q;

  //////////////////////////////////////////////////////////////////////
  // Write buffer bypass
  //////////////////////////////////////////////////////////////////////

  // Buffered write not yet in the data memory for this set
  assign bypass = wb_we_i & (idx_i == wb_idx_i);

  // Word copied to every slot, line byte enables pick the right one
  assign wb_line = {(`DC_BLK_BITS/`DC_XLEN){wb_data_i}};

  always_comb
  begin
    merged_line = cache_line_i;
    for (int i = 0; i < `DC_BLK_BITS/8; i++)
    begin
      if (bypass && wb_be_i[i])
      begin
        merged_line[i*8 +: 8] = wb_line[i*8 +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word select and output register
  //////////////////////////////////////////////////////////////////////

  assign cache_q = merged_line[offs_i*`DC_XLEN +: `DC_XLEN];

  // Miss data comes straight from the BIU
  always_ff @(posedge clk_i)
  begin
    q_o <= cache_hit_i ? cache_q : biu_q_i;
  end

endmodule

`default_nettype wire

/* rtl/dcache_write_buffer.sv */
// Data cache write-hit buffer
// Holds one write hit until the data memory acknowledges it

`default_nettype none

`include "dcache_hit_defines.svh"

module dcache_write_buffer
  import dcache_hit_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      wreq_i,
  input  logic      flush_i,
  input  logic      cache_hit_i,
  input  idx_t      idx_i,
  input  dat_offs_t offs_i,
  input  xlen_t     d_i,
  input  xbe_t      be_i,
  input  way_t      ways_hit_i,

  input  logic      writebuffer_ack_i,
  output logic      writebuffer_we_o,
  output idx_t      writebuffer_idx_o,
  output dat_offs_t writebuffer_offs_o,
  output xlen_t     writebuffer_data_o,
  output blk_be_t   writebuffer_be_o,
  output way_t      writebuffer_ways_hit_o
);

  logic write_hit;

  assign write_hit = wreq_i & cache_hit_i;

  // Flush wins, a new hit overwrites the single entry, ack drops we
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)                writebuffer_we_o <= 1'b0;
    else if (flush_i)           writebuffer_we_o <= 1'b0;
    else if (write_hit)         writebuffer_we_o <= 1'b1;
    else if (writebuffer_ack_i) writebuffer_we_o <= 1'b0;
  end

  // Payload, byte enables moved to the word's place in the line
  always_ff @(posedge clk_i)
  begin
    if (write_hit && !flush_i)
    begin
      writebuffer_idx_o      <= idx_i;
      writebuffer_offs_o     <= offs_i;
      writebuffer_data_o     <= d_i;
      writebuffer_be_o       <= blk_be_t'(be_i) << {offs_i, {`DC_WORD_LSB{1'b0}}};
      writebuffer_ways_hit_o <= ways_hit_i;
    end
  end

  a_no_we_on_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(writebuffer_we_o) |-> !$past(flush_i));

endmodule

`default_nettype wire
